//--- Makefile
SIM  := obj_dir/Vtb_data_cache
SRCS := $(wildcard hw/*.sv testbench/*.sv)

.PHONY: run clean

run: $(SIM)
	-./$(SIM) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

$(SIM): $(SRCS) data_cache.f
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_data_cache -f data_cache.f -o Vtb_data_cache

clean:
	rm -rf obj_dir sim.log

//--- data_cache.f
hw/cache_pkg.sv
hw/fill_if.sv
hw/way_if.sv
hw/line_fill.sv
hw/cache_store.sv
hw/cache_lookup.sv
hw/data_cache.sv
testbench/tb_data_cache.sv

//--- hw/cache_lookup.sv
`timescale 1ns/1ps

module cache_lookup import cache_pkg::*; (
    input  logic    clk,
    input  logic    reset_n,
    input  logic    i_req_valid,
    input  cpu_op_e i_req_op,
    input  addr_t   i_req_addr,
    input  word_t   i_req_wdata,
    output logic    o_resp_valid,
    output word_t   o_rdata,
    output logic    o_hit,
    output logic    o_busy,
    output logic    o_mem_write,
    output addr_t   o_mem_addr,
    output word_t   o_mem_wdata,
    output logic    o_miss,
    output addr_t   o_miss_addr,
    way_if.lookup   ways,
    fill_if.monitor fill
);

    lookup_state_e       state_q;
    lookup_state_e       state_d;
    cpu_op_e             op_q;
    addr_t               addr_q;
    word_t               wdata_q;
    logic [NUM_WAYS-1:0] hit_vec;
    logic                any_hit;
    logic                hit_way;
    offset_t             offset;

    assign offset = addr_offset(addr_q);

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = ways.way_valid[w] && (ways.way_tag[w] == addr_tag(addr_q));
        end
    end

    assign any_hit = |hit_vec;
    assign hit_way = hit_vec[1];  // at most one way can match

    assign ways.rd_index   = addr_index(addr_q);
    assign ways.upd_way    = hit_way;
    assign ways.upd_offset = offset;
    assign ways.upd_data   = wdata_q;

    always_comb begin
        state_d         = state_q;
        o_resp_valid    = 1'b0;
        o_hit           = 1'b0;
        o_mem_write     = 1'b0;
        o_miss          = 1'b0;
        ways.upd_valid  = 1'b0;
        ways.upd_write  = 1'b0;
        case (state_q)
            LK_IDLE: begin
                if (i_req_valid) begin
                    state_d = LK_CHECK;
                end
            end
            LK_CHECK: begin
                if (op_q == OP_WRITE) begin
                    o_mem_write    = 1'b1;  // write-through with no allocate
                    o_resp_valid   = 1'b1;
                    o_hit          = any_hit;
                    ways.upd_valid = any_hit;
                    ways.upd_write = 1'b1;
                    state_d        = LK_IDLE;
                end else if (any_hit) begin
                    o_resp_valid   = 1'b1;
                    o_hit          = 1'b1;
                    ways.upd_valid = 1'b1;
                    state_d        = LK_IDLE;
                end else begin
                    o_miss  = 1'b1;
                    state_d = LK_WAIT;
                end
            end
            LK_WAIT: begin
                if (fill.fill_valid) begin
                    o_resp_valid = 1'b1;
                    state_d      = LK_IDLE;
                end
            end
            default: state_d = LK_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state_q <= LK_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == LK_IDLE && i_req_valid) begin
            op_q    <= i_req_op;
            addr_q  <= i_req_addr;
            wdata_q <= i_req_wdata;
        end
    end

    // miss answer comes straight off the fill bus
    assign o_rdata = (state_q == LK_WAIT) ? fill.fill_line[offset]
                                          : ways.way_line[hit_way][offset];

    assign o_busy      = state_q != LK_IDLE;
    assign o_mem_addr  = addr_q;
    assign o_mem_wdata = wdata_q;
    assign o_miss_addr = {addr_tag(addr_q), addr_index(addr_q), {OFFSET_W{1'b0}}};

    a_no_req_while_busy: assert property (@(posedge clk) disable iff (!reset_n)
        i_req_valid |-> !o_busy);

endmodule

//--- hw/cache_pkg.sv
package cache_pkg;

    localparam int ADDR_W         = 16;
    localparam int DATA_W         = 16;
    localparam int OFFSET_W       = 2;   // addr[1:0]
    localparam int INDEX_W        = 1;   // addr[2]
    localparam int TAG_W          = 13;  // addr[15:3]
    localparam int WORDS_PER_LINE = 4;
    localparam int NUM_SETS       = 2;
    localparam int NUM_WAYS       = 2;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DATA_W-1:0]   word_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;

    // word 0 sits in the low 16 bits
    typedef word_t [WORDS_PER_LINE-1:0] line_t;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } cpu_op_e;

    typedef enum logic [2:0] {
        FILL_IDLE,
        FILL_W0,
        FILL_W1,
        FILL_W2,
        FILL_W3,
        FILL_DONE
    } fill_state_e;

    typedef enum logic [1:0] {
        LK_IDLE,
        LK_CHECK,
        LK_WAIT
    } lookup_state_e;

    function automatic tag_t addr_tag(input addr_t a);
        return a[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic index_t addr_index(input addr_t a);
        return a[OFFSET_W +: INDEX_W];
    endfunction

    function automatic offset_t addr_offset(input addr_t a);
        return a[OFFSET_W-1:0];
    endfunction

endpackage

//--- hw/cache_store.sv
`timescale 1ns/1ps

module cache_store import cache_pkg::*; (
    input  logic clk,
    input  logic reset_n,
    fill_if.sink fill,
    way_if.store ways
);

    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    logic [NUM_SETS-1:0] lru_q;  // way to evict next
    tag_t                tag_q  [NUM_SETS][NUM_WAYS];
    line_t               line_q [NUM_SETS][NUM_WAYS];
    logic                victim;

    // invalid way first, then the LRU way
    always_comb begin
        if (!valid_q[fill.fill_index][0]) begin
            victim = 1'b0;
        end else if (!valid_q[fill.fill_index][1]) begin
            victim = 1'b1;
        end else begin
            victim = lru_q[fill.fill_index];
        end
    end

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            ways.way_valid[w] = valid_q[ways.rd_index][w];
            ways.way_tag[w]   = tag_q[ways.rd_index][w];
            ways.way_line[w]  = line_q[ways.rd_index][w];
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
            lru_q <= '0;
        end else if (fill.fill_valid) begin
            valid_q[fill.fill_index][victim] <= 1'b1;
            lru_q[fill.fill_index]           <= ~victim;
        end else if (ways.upd_valid) begin
            lru_q[ways.rd_index] <= ~ways.upd_way;  // other way is now older
        end
    end

    always_ff @(posedge clk) begin
        if (fill.fill_valid) begin
            tag_q[fill.fill_index][victim]  <= fill.fill_tag;
            line_q[fill.fill_index][victim] <= fill.fill_line;
        end else if (ways.upd_valid && ways.upd_write) begin
            line_q[ways.rd_index][ways.upd_way][ways.upd_offset] <= ways.upd_data;
        end
    end

    // a fill only lands while the lookup stage waits, so no hit update then
    a_no_fill_and_update: assert property (@(posedge clk) disable iff (!reset_n)
        !(fill.fill_valid && ways.upd_valid));

endmodule

//--- hw/data_cache.sv
`timescale 1ns/1ps

module data_cache import cache_pkg::*; (
    input  logic    clk,
    input  logic    reset_n,
    input  logic    i_req_valid,
    input  cpu_op_e i_req_op,
    input  addr_t   i_req_addr,
    input  word_t   i_req_wdata,
    output logic    o_resp_valid,
    output word_t   o_rdata,
    output logic    o_hit,
    output logic    o_busy,
    output logic    o_mem_read,
    output logic    o_mem_write,
    output addr_t   o_mem_addr,
    output word_t   o_mem_wdata,
    input  word_t   i_mem_rdata
);

    addr_t fetch_addr;
    addr_t write_addr;
    logic  miss;
    addr_t miss_addr;

    fill_if fill_bus ();
    way_if  way_bus ();

    line_fill u_line_fill (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_miss      (miss),
        .i_miss_addr (miss_addr),
        .i_mem_rdata (i_mem_rdata),
        .o_mem_read  (o_mem_read),
        .o_mem_addr  (fetch_addr),
        .fill        (fill_bus.source)
    );

    cache_store u_cache_store (
        .clk     (clk),
        .reset_n (reset_n),
        .fill    (fill_bus.sink),
        .ways    (way_bus.store)
    );

    cache_lookup u_cache_lookup (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_req_valid  (i_req_valid),
        .i_req_op     (i_req_op),
        .i_req_addr   (i_req_addr),
        .i_req_wdata  (i_req_wdata),
        .o_resp_valid (o_resp_valid),
        .o_rdata      (o_rdata),
        .o_hit        (o_hit),
        .o_busy       (o_busy),
        .o_mem_write  (o_mem_write),
        .o_mem_addr   (write_addr),
        .o_mem_wdata  (o_mem_wdata),
        .o_miss       (miss),
        .o_miss_addr  (miss_addr),
        .ways         (way_bus.lookup),
        .fill         (fill_bus.monitor)
    );

    // fetch reads and write-through never overlap
    assign o_mem_addr = o_mem_read ? fetch_addr : write_addr;

endmodule

//--- hw/fill_if.sv
`timescale 1ns/1ps

// completed line from the fetcher as a one-cycle strobe
interface fill_if import cache_pkg::*; ();

    logic   fill_valid;
    index_t fill_index;
    tag_t   fill_tag;
    line_t  fill_line;

    modport source (
        output fill_valid, fill_index, fill_tag, fill_line
    );

    modport sink (
        input fill_valid, fill_index, fill_tag, fill_line
    );

    modport monitor (
        input fill_valid, fill_line  // lookup only needs the word
    );

endinterface

//--- hw/line_fill.sv
`timescale 1ns/1ps

module line_fill import cache_pkg::*; (
    input  logic   clk,
    input  logic   reset_n,
    input  logic   i_miss,
    input  addr_t  i_miss_addr,
    input  word_t  i_mem_rdata,
    output logic   o_mem_read,
    output addr_t  o_mem_addr,
    fill_if.source fill
);

    fill_state_e state_q;
    fill_state_e state_d;
    tag_t        tag_q;
    index_t      index_q;
    offset_t     rd_offset;
    word_t       word_q [3];  // words 0..2 of the line

    always_comb begin
        state_d    = state_q;
        rd_offset  = '0;
        o_mem_read = 1'b0;
        case (state_q)
            FILL_IDLE: begin
                if (i_miss) begin
                    state_d = FILL_W0;
                end
            end
            FILL_W0: begin
                o_mem_read = 1'b1;
                state_d    = FILL_W1;
            end
            FILL_W1: begin
                o_mem_read = 1'b1;
                rd_offset  = 2'd1;
                state_d    = FILL_W2;
            end
            FILL_W2: begin
                o_mem_read = 1'b1;
                rd_offset  = 2'd2;
                state_d    = FILL_W3;
            end
            FILL_W3: begin
                o_mem_read = 1'b1;
                rd_offset  = 2'd3;
                state_d    = FILL_DONE;
            end
            default: state_d = FILL_IDLE;  // FILL_DONE included
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state_q <= FILL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // data returns one cycle behind each read
    always_ff @(posedge clk) begin
        if (state_q == FILL_IDLE && i_miss) begin
            tag_q   <= addr_tag(i_miss_addr);
            index_q <= addr_index(i_miss_addr);
        end
        case (state_q)
            FILL_W1: word_q[0] <= i_mem_rdata;
            FILL_W2: word_q[1] <= i_mem_rdata;
            FILL_W3: word_q[2] <= i_mem_rdata;
            default: ;
        endcase
    end

    assign o_mem_addr = {tag_q, index_q, rd_offset};

    assign fill.fill_valid = state_q == FILL_DONE;
    assign fill.fill_index = index_q;
    assign fill.fill_tag   = tag_q;
    assign fill.fill_line  = {i_mem_rdata, word_q[2], word_q[1], word_q[0]};  // last word off the bus

    // lookup must not start a second miss while a fetch is running
    a_miss_when_idle: assert property (@(posedge clk) disable iff (!reset_n)
        i_miss |-> state_q == FILL_IDLE);

endmodule

//--- hw/way_if.sv
`timescale 1ns/1ps

interface way_if import cache_pkg::*; ();

    // set select and hit update driven by the lookup stage
    index_t  rd_index;
    logic    upd_valid;
    logic    upd_way;
    logic    upd_write;
    offset_t upd_offset;
    word_t   upd_data;

    // both ways of rd_index driven by the store
    logic [NUM_WAYS-1:0] way_valid;
    tag_t [NUM_WAYS-1:0] way_tag;
    line_t [NUM_WAYS-1:0] way_line;

    modport store (
        input  rd_index, upd_valid, upd_way, upd_write, upd_offset, upd_data,
        output way_valid, way_tag, way_line
    );

    modport lookup (
        output rd_index, upd_valid, upd_way, upd_write, upd_offset, upd_data,
        input  way_valid, way_tag, way_line
    );

endinterface

//--- testbench/cache_patterns.txt
// op addr wdata rdata hit, all hex
// op 0 read, 1 write, 2 reset pulse; rdata and hit are the expected response
// cold miss, then the same line hits
0 0040 0000 c3e5 0
0 0043 0000 c3e6 1
// write hit updates the cached word
1 0041 1234 0000 1
0 0041 0000 1234 1
// write miss goes to memory only
1 0105 beef 0000 0
0 0105 0000 beef 0
// lru in set 0, a=0040 b=0080 c=00c0
0 0082 0000 c327 0
0 0040 0000 c3e5 1
0 00c0 0000 c365 0
0 0041 0000 1234 1
0 0080 0000 c325 0
// reset drops every line
2 0000 0000 0000 0
0 0041 0000 1234 0
0 0042 0000 c3e7 1
// set 1 after reset
0 0107 0000 c2a2 0
0 0105 0000 beef 1
1 0106 5a5a 0000 1
0 0106 0000 5a5a 1
0 1004 0000 d3a1 0
0 2005 0000 e3a0 0
0 1006 0000 d3a3 1
0 0106 0000 5a5a 0
0 2007 0000 e3a2 0

//--- testbench/tb_data_cache.sv
`timescale 1ns/1ps

module tb_data_cache import cache_pkg::*; ();

    localparam int NUM_PATTERNS = 23;
    localparam int FIELDS       = 5;  // op addr wdata rdata hit
    localparam int TIMEOUT      = 50;

    logic        clk;
    logic        reset_n;
    logic        req_valid;
    cpu_op_e     req_op;
    addr_t       req_addr;
    word_t       req_wdata;
    logic        resp_valid;
    word_t       rdata;
    logic        hit;
    logic        busy;
    logic        mem_read;
    logic        mem_write;
    addr_t       mem_addr;
    word_t       mem_wdata;
    word_t       mem_rdata;

    word_t       mem [0:(1 << ADDR_W)-1];
    addr_t       rd_log [$];  // every o_mem_read address seen
    logic [15:0] pat_words [0:NUM_PATTERNS*FIELDS-1];
    integer      seed;
    int          mismatch_count;
    int          failure_count;
    logic        timed_out;

    data_cache dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_req_valid  (req_valid),
        .i_req_op     (req_op),
        .i_req_addr   (req_addr),
        .i_req_wdata  (req_wdata),
        .o_resp_valid (resp_valid),
        .o_rdata      (rdata),
        .o_hit        (hit),
        .o_busy       (busy),
        .o_mem_read   (mem_read),
        .o_mem_write  (mem_write),
        .o_mem_addr   (mem_addr),
        .o_mem_wdata  (mem_wdata),
        .i_mem_rdata  (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // memory model with read data valid the cycle after o_mem_read
    initial begin
        for (int a = 0; a < (1 << ADDR_W); a++) begin
            mem[a] = word_t'(a) ^ 16'hc3a5;
        end
        mem_rdata <= '0;
        forever begin
            @(posedge clk);
            if (mem_write === 1'b1) begin
                mem[mem_addr] = mem_wdata;
            end
            if (mem_read === 1'b1) begin
                mem_rdata <= mem[mem_addr];
            end
        end
    end

    always @(negedge clk) begin
        if (reset_n === 1'b1 && mem_read === 1'b1) begin
            rd_log.push_back(mem_addr);
        end
    end

    task automatic check_word(input int pat, input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            mismatch_count++;
            $display("mismatch pattern %0d %s: expected %h actual %h", pat, what, exp, act);
        end
    endtask

    task automatic check_addr(input int pat, input string what, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            mismatch_count++;
            $display("mismatch pattern %0d %s: expected %h actual %h", pat, what, exp, act);
        end
    endtask

    task automatic check_hit(input int pat, input logic exp, input logic act);
        if (act !== exp) begin
            mismatch_count++;
            $display("mismatch pattern %0d hit: expected %b actual %b", pat, exp, act);
        end
    endtask

    task automatic check_count(input int pat, input string what, input int exp, input int act);
        if (act != exp) begin
            mismatch_count++;
            $display("mismatch pattern %0d %s: expected %0d actual %0d", pat, what, exp, act);
        end
    endtask

    // called right after a rising edge where reset_n was released
    task automatic check_idle(input string when);
        @(negedge clk);
        if (resp_valid !== 1'b0 || busy !== 1'b0 || mem_read !== 1'b0 || mem_write !== 1'b0) begin
            failure_count++;
            $display("cache outputs not idle %s", when);
        end
        @(posedge clk);
    endtask

    task automatic pulse_reset();
        reset_n <= 1'b0;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
        check_idle("after mid-run reset");
    endtask

    // starts and ends on a rising edge
    task automatic run_request(input int pat, input cpu_op_e op, input addr_t addr,
                               input word_t wdata, input word_t exp_rdata, input logic exp_hit);
        int    start;
        int    cycles;
        int    new_reads;
        logic  seen;
        logic  busy_low;
        addr_t base;
        start    = rd_log.size();
        base     = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        cycles   = 0;
        seen     = 1'b0;
        busy_low = 1'b0;
        req_valid <= 1'b1;
        req_op    <= op;
        req_addr  <= addr;
        req_wdata <= wdata;
        @(posedge clk);
        req_valid <= 1'b0;
        while (!seen && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            seen = resp_valid === 1'b1;
            if (busy !== 1'b1) begin
                busy_low = 1'b1;
            end
        end
        if (!seen) begin
            failure_count++;
            timed_out = 1'b1;
            $display("pattern %0d got no response within %0d cycles", pat, TIMEOUT);
        end else begin
            if (busy_low) begin
                failure_count++;
                $display("pattern %0d saw o_busy low before the response ended", pat);
            end
            check_hit(pat, exp_hit, hit);
            if (op == OP_READ) begin
                check_word(pat, "rdata", exp_rdata, rdata);
                check_count(pat, "latency", exp_hit ? 1 : 6, cycles);
            end else begin
                check_count(pat, "latency", 1, cycles);
                if (mem_write !== 1'b1) begin
                    failure_count++;
                    $display("pattern %0d write response came without o_mem_write", pat);
                end
                check_addr(pat, "mem addr", addr, mem_addr);
                check_word(pat, "mem wdata", wdata, mem_wdata);
            end
            @(posedge clk);
            new_reads = rd_log.size() - start;
            if (op == OP_READ && !exp_hit) begin
                check_count(pat, "mem reads", 4, new_reads);
                for (int i = 0; i < new_reads && i < 4; i++) begin
                    check_addr(pat, "mem read addr", base + addr_t'(i), rd_log[start + i]);
                end
            end else begin
                check_count(pat, "mem reads", 0, new_reads);
            end
        end
    endtask

    initial begin
        logic [15:0] op_field;
        int          base;
        int          gap;
        seed           = 32'hcc8c_320e;
        mismatch_count = 0;
        failure_count  = 0;
        timed_out      = 1'b0;
        reset_n        <= 1'b0;
        req_valid      <= 1'b0;
        req_op         <= OP_READ;
        req_addr       <= '0;
        req_wdata      <= '0;
        $readmemh("testbench/cache_patterns.txt", pat_words);
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
        check_idle("after power-on reset");

        for (int p = 0; p < NUM_PATTERNS && !timed_out; p++) begin
            base     = p * FIELDS;
            op_field = pat_words[base];
            gap      = $random(seed) & 3;
            repeat (gap) @(posedge clk);
            case (op_field)
                16'd0: run_request(p, OP_READ, pat_words[base+1], pat_words[base+2],
                                   pat_words[base+3], pat_words[base+4][0]);
                16'd1: run_request(p, OP_WRITE, pat_words[base+1], pat_words[base+2],
                                   pat_words[base+3], pat_words[base+4][0]);
                16'd2: pulse_reset();
                default: begin
                    failure_count++;
                    $display("pattern %0d has an unknown op %h", p, op_field);
                end
            endcase
        end

        $display("checks done: %0d mismatches, %0d other failures",
                 mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
